/* Bender.yml */
package:
  name: mem_shim

sources:
  - files:
      - design/mem_shim_pkg.sv
      - design/mem_req_if.sv
      - design/client_req_port.sv
      - design/read_rsp_sorter.sv
      - design/platform_port.sv
      - design/mem_shim_top.sv
  - target: test
    files:
      - tests/mem_shim_asserts.sv
      - tests/tb_mem_shim.sv

/* design/client_req_port.sv */
/*
 * Client request staging: two-entry read and write FIFOs, read tag capture
 */

`timescale 1ns/100ps

module client_req_port (
    input  logic                clk,
    input  logic                reset_n,
    input  mem_shim_pkg::addr_t rd_req_addr,
    input  logic                rd_req_enable,
    output logic                rd_req_rdy,
    input  mem_shim_pkg::addr_t wr_req_addr,
    input  mem_shim_pkg::line_t wr_req_data,
    input  logic                wr_req_enable,
    output logic                wr_req_rdy,
    input  mem_shim_pkg::tag_t  next_tag,
    input  logic                rob_full,
    output logic                tag_alloc,
    mem_req_if.driver           req
);

    // Read stage storage, each entry keeps its address and its tag
    mem_shim_pkg::addr_t rd_addr_q [2];
    mem_shim_pkg::tag_t  rd_tag_q  [2];
    logic                rd_wptr;
    logic                rd_rptr;
    logic [1:0]          rd_cnt;
    logic                rd_push;
    logic                rd_pop;

    // Write stage storage
    mem_shim_pkg::addr_t wr_addr_q [2];
    mem_shim_pkg::line_t wr_data_q [2];
    logic                wr_wptr;
    logic                wr_rptr;
    logic [1:0]          wr_cnt;
    logic                wr_push;
    logic                wr_pop;

    // ====================
    // Acceptance
    // ====================

    // A read also needs a free slot in the reorder buffer
    assign rd_req_rdy = (rd_cnt != 2'd2) && !rob_full;
    assign wr_req_rdy = (wr_cnt != 2'd2);

    assign rd_push = rd_req_enable && rd_req_rdy;
    assign wr_push = wr_req_enable && wr_req_rdy;
    assign rd_pop  = req.rd_valid && req.rd_take;
    assign wr_pop  = req.wr_valid && req.wr_take;

    // The sorter advances its allocation pointer on the same edge
    assign tag_alloc = rd_push;

    // ====================
    // Stage pointers
    // ====================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_wptr <= 1'b0;
            rd_rptr <= 1'b0;
            rd_cnt  <= 2'd0;
            wr_wptr <= 1'b0;
            wr_rptr <= 1'b0;
            wr_cnt  <= 2'd0;
        end
        else
        begin
            // Pointers toggle since each stage holds exactly two entries
            rd_wptr <= rd_wptr ^ rd_push;
            rd_rptr <= rd_rptr ^ rd_pop;
            rd_cnt  <= rd_cnt + 2'(rd_push) - 2'(rd_pop);
            wr_wptr <= wr_wptr ^ wr_push;
            wr_rptr <= wr_rptr ^ wr_pop;
            wr_cnt  <= wr_cnt + 2'(wr_push) - 2'(wr_pop);
        end
    end

    // Entry payloads, written only on acceptance
    always_ff @(posedge clk)
    begin
        if (rd_push)
        begin
            rd_addr_q[rd_wptr] <= rd_req_addr;
            rd_tag_q[rd_wptr]  <= next_tag;
        end
        if (wr_push)
        begin
            wr_addr_q[wr_wptr] <= wr_req_addr;
            wr_data_q[wr_wptr] <= wr_req_data;
        end
    end

    // Oldest entry of each stage is offered to the platform side
    assign req.rd_valid = (rd_cnt != 2'd0);
    assign req.rd_addr  = rd_addr_q[rd_rptr];
    assign req.rd_tag   = rd_tag_q[rd_rptr];
    assign req.wr_valid = (wr_cnt != 2'd0);
    assign req.wr_addr  = wr_addr_q[wr_rptr];
    assign req.wr_data  = wr_data_q[wr_rptr];

endmodule

/* design/mem_req_if.sv */
/*
 * Staged request link between the client side and the platform side
 */

`timescale 1ns/100ps

interface mem_req_if (
    input logic clk
);

    // Read channel, tag was assigned when the client read was accepted
    logic                rd_valid;
    mem_shim_pkg::addr_t rd_addr;
    mem_shim_pkg::tag_t  rd_tag;
    logic                rd_take;

    // Write channel
    logic                wr_valid;
    mem_shim_pkg::addr_t wr_addr;
    mem_shim_pkg::line_t wr_data;
    logic                wr_take;

    // A request moves on any edge where its valid and take are both high
    // Payload stays stable on the driver side until it is taken
    modport driver (
        input  clk,
        output rd_valid, rd_addr, rd_tag, wr_valid, wr_addr, wr_data,
        input  rd_take, wr_take
    );

    modport receiver (
        input  clk,
        input  rd_valid, rd_addr, rd_tag, wr_valid, wr_addr, wr_data,
        output rd_take, wr_take
    );

endinterface

/* design/mem_shim_pkg.sv */
/*
 * Shared widths, vector typedefs and the sorter release state enum
 * for the client memory driver
 */

package mem_shim_pkg;

    // ====================
    // Widths
    // ====================

    // Cache-line address width
    parameter int ADDR_W = 32;

    // Line data width, kept narrow so simulation stays light
    parameter int DATA_W = 64;

    // Widest read tag supported, which bounds the reorder buffer at 16 slots
    parameter int MAX_TAG_W = 4;

    // Credit counters hold up to 31 credits
    parameter int CREDIT_W = 5;

    // ====================
    // Types
    // ====================

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DATA_W-1:0]    line_t;

    // Only the low bits implied by the reorder buffer depth carry meaning
    typedef logic [MAX_TAG_W-1:0] tag_t;

    typedef logic [CREDIT_W-1:0]  credit_t;

    // Release machine of the read response sorter
    // Drain means a line is being presented to the client this cycle
    typedef enum logic {
        idle  = 1'b0,
        drain = 1'b1
    } sorter_state_t;

endpackage

/* design/mem_shim_top.sv */
/*
 * Client memory driver top: request staging, read reorder buffer, platform port
 */

`timescale 1ns/100ps

module mem_shim_top #(
    parameter int ROB_DEPTH   = 8,
    parameter int MAX_CREDITS = 8
) (
    input  logic                clk,
    input  logic                reset_n,

    // Client read request and in-order response
    input  mem_shim_pkg::addr_t rd_req_addr,
    input  logic                rd_req_enable,
    output logic                rd_req_rdy,
    output logic                rd_rsp_valid,
    output mem_shim_pkg::line_t rd_rsp_data,

    // Client write request and completion pulse
    input  mem_shim_pkg::addr_t wr_req_addr,
    input  mem_shim_pkg::line_t wr_req_data,
    input  logic                wr_req_enable,
    output logic                wr_req_rdy,
    output logic                wr_ack,

    // Platform credit grants
    input  logic                plat_rd_credit,
    input  logic                plat_wr_credit,

    // Platform requests
    output logic                plat_rd_valid,
    output mem_shim_pkg::addr_t plat_rd_addr,
    output mem_shim_pkg::tag_t  plat_rd_tag,
    output logic                plat_wr_valid,
    output mem_shim_pkg::addr_t plat_wr_addr,
    output mem_shim_pkg::line_t plat_wr_data,

    // Platform responses, reads may arrive in any order
    input  logic                plat_rd_rsp_valid,
    input  mem_shim_pkg::tag_t  plat_rd_rsp_tag,
    input  mem_shim_pkg::line_t plat_rd_rsp_data,
    input  logic                plat_wr_rsp_valid
);

    // Tag allocation handshake between staging and the sorter
    logic               tag_alloc;
    mem_shim_pkg::tag_t next_tag;
    logic               rob_full;

    mem_req_if req_link (.clk(clk));

    client_req_port req_stage (
        .clk, .reset_n,
        .rd_req_addr, .rd_req_enable, .rd_req_rdy,
        .wr_req_addr, .wr_req_data, .wr_req_enable, .wr_req_rdy,
        .next_tag, .rob_full, .tag_alloc,
        .req (req_link.driver)
    );

    read_rsp_sorter #(.ROB_DEPTH(ROB_DEPTH)) rsp_sorter (
        .clk, .reset_n, .tag_alloc, .next_tag, .rob_full,
        .plat_rd_rsp_valid, .plat_rd_rsp_tag, .plat_rd_rsp_data,
        .rd_rsp_valid, .rd_rsp_data
    );

    platform_port #(.MAX_CREDITS(MAX_CREDITS)) plat_port (
        .clk, .reset_n, .plat_rd_credit, .plat_wr_credit, .plat_wr_rsp_valid,
        .req (req_link.receiver),
        .plat_rd_valid, .plat_rd_addr, .plat_rd_tag,
        .plat_wr_valid, .plat_wr_addr, .plat_wr_data, .wr_ack
    );

endmodule

/* design/platform_port.sv */
/*
 * Platform side: per-channel credit tracking, request issue, write acknowledge
 */

`timescale 1ns/100ps

module platform_port #(
    parameter int MAX_CREDITS = 8
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                plat_rd_credit,
    input  logic                plat_wr_credit,
    input  logic                plat_wr_rsp_valid,
    mem_req_if.receiver         req,
    output logic                plat_rd_valid,
    output mem_shim_pkg::addr_t plat_rd_addr,
    output mem_shim_pkg::tag_t  plat_rd_tag,
    output logic                plat_wr_valid,
    output mem_shim_pkg::addr_t plat_wr_addr,
    output mem_shim_pkg::line_t plat_wr_data,
    output logic                wr_ack
);

    mem_shim_pkg::credit_t rd_credit;
    mem_shim_pkg::credit_t wr_credit;

    // A grant and a spend on the same edge cancel out
    // The count is held at MAX_CREDITS should the platform overgrant
    function automatic mem_shim_pkg::credit_t next_credit(
        mem_shim_pkg::credit_t cur,
        logic                  grant,
        logic                  spend
    );
        mem_shim_pkg::credit_t result;
        result = cur;
        if (grant && !spend && (cur != mem_shim_pkg::credit_t'(MAX_CREDITS)))
        begin
            result = cur + 1'b1;
        end
        else if (!grant && spend)
        begin
            result = cur - 1'b1;
        end
        return result;
    endfunction

    // ====================
    // Issue
    // ====================

    // Staged requests are taken only while their channel holds a credit
    assign req.rd_take = req.rd_valid && (rd_credit != '0);
    assign req.wr_take = req.wr_valid && (wr_credit != '0);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_credit     <= '0;
            wr_credit     <= '0;
            plat_rd_valid <= 1'b0;
            plat_wr_valid <= 1'b0;
            wr_ack        <= 1'b0;
        end
        else
        begin
            rd_credit     <= next_credit(rd_credit, plat_rd_credit, req.rd_take);
            wr_credit     <= next_credit(wr_credit, plat_wr_credit, req.wr_take);
            // Each taken request is held on the platform for exactly one cycle
            plat_rd_valid <= req.rd_take;
            plat_wr_valid <= req.wr_take;
            // Writes complete in order, so the acknowledge is a plain delay
            wr_ack        <= plat_wr_rsp_valid;
        end
    end

    // Request payload registers, loaded only when a request is taken
    always_ff @(posedge clk)
    begin
        if (req.rd_take)
        begin
            plat_rd_addr <= req.rd_addr;
            plat_rd_tag  <= req.rd_tag;
        end
        if (req.wr_take)
        begin
            plat_wr_addr <= req.wr_addr;
            plat_wr_data <= req.wr_data;
        end
    end

endmodule

/* design/read_rsp_sorter.sv */
/*
 * Read reorder buffer: tag allocation, out-of-order capture, in-order release
 */

`timescale 1ns/100ps

module read_rsp_sorter #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                tag_alloc,
    output mem_shim_pkg::tag_t  next_tag,
    output logic                rob_full,
    input  logic                plat_rd_rsp_valid,
    input  mem_shim_pkg::tag_t  plat_rd_rsp_tag,
    input  mem_shim_pkg::line_t plat_rd_rsp_data,
    output logic                rd_rsp_valid,
    output mem_shim_pkg::line_t rd_rsp_data
);

    // Slot index width and a count wide enough to reach ROB_DEPTH
    localparam int IDX_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    // Allocation and release both walk the slots in ring order
    logic [IDX_W-1:0]          alloc_ptr;
    logic [IDX_W-1:0]          head_ptr;
    logic [CNT_W-1:0]          outstanding;

    // One data slot and one filled flag per tag
    mem_shim_pkg::line_t       slot_data [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]      filled;

    mem_shim_pkg::sorter_state_t state;

    logic [IDX_W-1:0]          rsp_idx;
    logic                      head_ready;

    // ====================
    // Tag allocation
    // ====================

    // Tags are simply slot numbers, upper tag bits stay zero
    assign next_tag = mem_shim_pkg::tag_t'(alloc_ptr);

    // Every tag is in flight until its line has been released
    assign rob_full = (outstanding == CNT_W'(ROB_DEPTH));

    // Only the low tag bits select a slot
    assign rsp_idx = plat_rd_rsp_tag[IDX_W-1:0];

    // The oldest outstanding read has its data waiting
    assign head_ready = filled[head_ptr];

    // ====================
    // Control state
    // ====================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            alloc_ptr   <= '0;
            head_ptr    <= '0;
            outstanding <= '0;
            filled      <= '0;
            state       <= mem_shim_pkg::idle;
        end
        else
        begin
            if (tag_alloc)
            begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end

            outstanding <= outstanding + CNT_W'(tag_alloc) - CNT_W'(head_ready);

            // A response never targets the head slot while it is still filled,
            // so the set and the clear below cannot hit the same slot
            if (plat_rd_rsp_valid)
            begin
                filled[rsp_idx] <= 1'b1;
            end

            // Release machine stays in drain as long as the head keeps filling
            if (head_ready)
            begin
                filled[head_ptr] <= 1'b0;
                head_ptr         <= head_ptr + 1'b1;
                state            <= mem_shim_pkg::drain;
            end
            else
            begin
                state <= mem_shim_pkg::idle;
            end
        end
    end

    // ====================
    // Data path
    // ====================

    always_ff @(posedge clk)
    begin
        // Out-of-order capture by tag
        if (plat_rd_rsp_valid)
        begin
            slot_data[rsp_idx] <= plat_rd_rsp_data;
        end

        // The head line moves to the output register as it is released
        if (head_ready)
        begin
            rd_rsp_data <= slot_data[head_ptr];
        end
    end

    // One line per cycle leaves while the machine is in drain
    assign rd_rsp_valid = (state == mem_shim_pkg::drain);

endmodule

/* flist.f */
design/mem_shim_pkg.sv
design/mem_req_if.sv
design/client_req_port.sv
design/read_rsp_sorter.sv
design/platform_port.sv
design/mem_shim_top.sv
tests/mem_shim_asserts.sv
tests/tb_mem_shim.sv

/* tests/mem_shim_asserts.sv */
/*
 * Protocol assertions on the memory driver top-level ports
 */

`timescale 1ns/100ps

module mem_shim_asserts (
    input logic clk,
    input logic reset_n,
    input logic rd_req_enable,
    input logic rd_req_rdy,
    input logic wr_req_enable,
    input logic wr_req_rdy,
    input logic plat_rd_credit,
    input logic plat_rd_valid,
    input logic rd_rsp_valid,
    input logic wr_ack
);

    // Read credits granted by the platform and not yet used by an issued read
    int rd_credit_free;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_credit_free <= 0;
        end
        else
        begin
            rd_credit_free <= rd_credit_free + int'(plat_rd_credit) - int'(plat_rd_valid);
        end
    end

    // The client only raises an enable while the matching ready is high
    assert property (@(posedge clk) disable iff (!reset_n) rd_req_enable |-> rd_req_rdy)
        else $error("Client read enable while rd_req_rdy is low");

    assert property (@(posedge clk) disable iff (!reset_n) wr_req_enable |-> wr_req_rdy)
        else $error("Client write enable while wr_req_rdy is low");

    assert property (@(posedge clk) disable iff (!reset_n) plat_rd_valid |-> (rd_credit_free > 0))
        else $error("Platform read issued without an unused read credit");

    // Outputs have been cleared by the first reset edge
    assert property (@(posedge clk) (!reset_n ##1 !reset_n) |-> (!rd_rsp_valid && !wr_ack))
        else $error("Client response outputs active during reset");

endmodule

/* tests/tb_mem_shim.sv */
/*
 * Testbench for the client memory driver: clock, reset, random client traffic,
 * platform memory model with reordered responses, reference model, checks, timeout
 */

`timescale 1ns/100ps

module tb_mem_shim;

    localparam int ROB_DEPTH   = 8;
    localparam int MAX_CREDITS = 8;
    localparam int SEED        = 96;

    // Preloaded read region and write region never overlap
    localparam mem_shim_pkg::addr_t READ_BASE  = 32'h1000_0000;
    localparam int                  READ_SPAN  = 256;
    localparam mem_shim_pkg::addr_t WRITE_BASE = 32'h2000_0000;
    localparam int                  WRITE_SPAN = 16;

    localparam int P1_READS  = 60;
    localparam int P1_WRITES = 40;

    // Credit hold accepts at most the banked credits plus a full stage per channel
    localparam int TOTAL_REQ = P1_READS + P1_WRITES + WRITE_SPAN
                             + 2 * (MAX_CREDITS + 2) + ROB_DEPTH;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_REQ + 1000;

    logic                clk;
    logic                reset_n;
    mem_shim_pkg::addr_t rd_req_addr;
    logic                rd_req_enable;
    logic                rd_req_rdy;
    logic                rd_rsp_valid;
    mem_shim_pkg::line_t rd_rsp_data;
    mem_shim_pkg::addr_t wr_req_addr;
    mem_shim_pkg::line_t wr_req_data;
    logic                wr_req_enable;
    logic                wr_req_rdy;
    logic                wr_ack;
    logic                plat_rd_credit;
    logic                plat_wr_credit;
    logic                plat_rd_valid;
    mem_shim_pkg::addr_t plat_rd_addr;
    mem_shim_pkg::tag_t  plat_rd_tag;
    logic                plat_wr_valid;
    mem_shim_pkg::addr_t plat_wr_addr;
    mem_shim_pkg::line_t plat_wr_data;
    logic                plat_rd_rsp_valid;
    mem_shim_pkg::tag_t  plat_rd_rsp_tag;
    mem_shim_pkg::line_t plat_rd_rsp_data;
    logic                plat_wr_rsp_valid;

    // Reference model: expected read data and issue order per channel
    mem_shim_pkg::line_t ref_mem [mem_shim_pkg::addr_t];
    mem_shim_pkg::line_t exp_rd_q [$];
    mem_shim_pkg::addr_t exp_rd_addr_q [$];
    mem_shim_pkg::addr_t exp_wr_addr_q [$];
    mem_shim_pkg::line_t exp_wr_data_q [$];
    int rd_accepted = 0;
    int rd_returned = 0;
    int wr_accepted = 0;
    int ack_total   = 0;
    int wr_rsp_seen = 0;

    // Platform model: memory, outstanding requests and credit bookkeeping
    mem_shim_pkg::line_t plat_mem [mem_shim_pkg::addr_t];
    mem_shim_pkg::addr_t pend_rd_addr [$];
    mem_shim_pkg::tag_t  pend_rd_tag [$];
    mem_shim_pkg::addr_t pend_wr_addr [$];
    mem_shim_pkg::line_t pend_wr_data [$];
    int pend_wr_due [$];
    int rd_granted = 0;
    int wr_granted = 0;
    int rd_spent   = 0;
    int wr_spent   = 0;
    int rsp_pick;
    logic credit_hold = 1'b0;
    logic rsp_hold    = 1'b0;
    logic plat_active;
    logic credit_hold_now;
    logic rsp_hold_now;

    int cycles = 0;

    mem_shim_top #(.ROB_DEPTH(ROB_DEPTH), .MAX_CREDITS(MAX_CREDITS)) dut (.*);

    bind mem_shim_top mem_shim_asserts protocol_checks (
        .clk, .reset_n, .rd_req_enable, .rd_req_rdy, .wr_req_enable, .wr_req_rdy,
        .plat_rd_credit, .plat_rd_valid, .rd_rsp_valid, .wr_ack
    );

    // ====================
    // Helpers and checks
    // ====================

    // Preload pattern mixes every address bit into both halves of the line
    function automatic mem_shim_pkg::line_t preload_line(mem_shim_pkg::addr_t a);
        return {a * 32'h9E37_79B1, a ^ 32'hC3A5_0F96};
    endfunction

    function automatic mem_shim_pkg::line_t expected_read(mem_shim_pkg::addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : preload_line(a);
    endfunction

    function automatic mem_shim_pkg::line_t platform_read(mem_shim_pkg::addr_t a);
        return plat_mem.exists(a) ? plat_mem[a] : preload_line(a);
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_line(string name, mem_shim_pkg::line_t got, mem_shim_pkg::line_t exp);
        if (got !== exp)
        begin
            report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_addr(string name, mem_shim_pkg::addr_t got, mem_shim_pkg::addr_t exp);
        if (got !== exp)
        begin
            report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_tag(string name, mem_shim_pkg::tag_t got, mem_shim_pkg::tag_t exp);
        if (got !== exp)
        begin
            report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp)
        begin
            report_failure($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    // Every accepted request has reached the platform and has been answered
    function automatic bit drained();
        return (exp_rd_addr_q.size() == 0) && (exp_wr_addr_q.size() == 0)
            && (pend_rd_tag.size() == 0) && (pend_wr_addr.size() == 0);
    endfunction

    // ====================
    // Clock and timeout
    // ====================

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
        begin
            report_failure($sformatf("Run timed out after %0d cycles", cycles));
        end
    end

    // ====================
    // Monitor
    // ====================

    // Sampled at the falling edge, where inputs and registered outputs are settled
    always @(negedge clk)
    begin
        if (reset_n)
        begin
            if (rd_req_enable && rd_req_rdy)
            begin
                exp_rd_q.push_back(expected_read(rd_req_addr));
                exp_rd_addr_q.push_back(rd_req_addr);
                rd_accepted++;
            end
            if (wr_req_enable && wr_req_rdy)
            begin
                ref_mem[wr_req_addr] = wr_req_data;
                exp_wr_addr_q.push_back(wr_req_addr);
                exp_wr_data_q.push_back(wr_req_data);
                wr_accepted++;
            end
            // Requests must reach the platform in acceptance order
            if (plat_rd_valid)
            begin
                if (exp_rd_addr_q.size() == 0)
                begin
                    report_failure("Platform read issued with no accepted read waiting");
                end
                else
                begin
                    check_addr("plat_rd_addr", plat_rd_addr, exp_rd_addr_q.pop_front());
                    // Tags walk the slot ring in issue order, starting at slot 0
                    check_tag("plat_rd_tag", plat_rd_tag,
                              mem_shim_pkg::tag_t'(rd_spent % ROB_DEPTH));
                    pend_rd_addr.push_back(plat_rd_addr);
                    pend_rd_tag.push_back(plat_rd_tag);
                    rd_spent++;
                end
            end
            if (plat_wr_valid)
            begin
                if (exp_wr_addr_q.size() == 0)
                begin
                    report_failure("Platform write issued with no accepted write waiting");
                end
                else
                begin
                    check_addr("plat_wr_addr", plat_wr_addr, exp_wr_addr_q.pop_front());
                    check_line("plat_wr_data", plat_wr_data, exp_wr_data_q.pop_front());
                    pend_wr_addr.push_back(plat_wr_addr);
                    pend_wr_data.push_back(plat_wr_data);
                    pend_wr_due.push_back(cycles + 1 + int'($urandom % 6));
                    wr_spent++;
                end
            end
            // Client read responses come back in acceptance order
            if (rd_rsp_valid)
            begin
                if (exp_rd_q.size() == 0)
                begin
                    report_failure("Read response arrived with no read outstanding");
                end
                else
                begin
                    check_line("rd_rsp_data", rd_rsp_data, exp_rd_q.pop_front());
                    rd_returned++;
                end
            end
            // Each acknowledge trails its platform write response by one edge
            ack_total += int'(wr_ack);
            check_count("wr_ack total", ack_total, wr_rsp_seen);
            wr_rsp_seen += int'(plat_wr_rsp_valid);
        end
    end

    // ====================
    // Platform model
    // ====================

    always @(posedge clk)
    begin
        plat_active     = reset_n;
        credit_hold_now = credit_hold;
        rsp_hold_now    = rsp_hold;
        #1;
        plat_rd_credit    = 1'b0;
        plat_wr_credit    = 1'b0;
        plat_rd_rsp_valid = 1'b0;
        plat_wr_rsp_valid = 1'b0;
        if (plat_active)
        begin
            // Grants stay within MAX_CREDITS of the credits already spent
            if (!credit_hold_now && (rd_granted - rd_spent < MAX_CREDITS) && ($urandom % 2 == 0))
            begin
                plat_rd_credit = 1'b1;
                rd_granted++;
            end
            if (!credit_hold_now && (wr_granted - wr_spent < MAX_CREDITS) && ($urandom % 2 == 0))
            begin
                plat_wr_credit = 1'b1;
                wr_granted++;
            end
            // Any outstanding read may be answered, which scrambles the order
            if (!rsp_hold_now && (pend_rd_tag.size() > 0) && ($urandom % 3 != 0))
            begin
                rsp_pick          = int'($urandom % pend_rd_tag.size());
                plat_rd_rsp_tag   = pend_rd_tag[rsp_pick];
                plat_rd_rsp_data  = platform_read(pend_rd_addr[rsp_pick]);
                plat_rd_rsp_valid = 1'b1;
                pend_rd_tag.delete(rsp_pick);
                pend_rd_addr.delete(rsp_pick);
            end
            // Writes land in memory when they are answered
            if ((pend_wr_addr.size() > 0) && (pend_wr_due[0] <= cycles))
            begin
                plat_mem[pend_wr_addr[0]] = pend_wr_data[0];
                plat_wr_rsp_valid = 1'b1;
                pend_wr_addr.delete(0);
                pend_wr_data.delete(0);
                pend_wr_due.delete(0);
            end
        end
    end

    // ====================
    // Stimulus
    // ====================

    // Once the platform is quiet the sorter releases at most ROB_DEPTH lines,
    // one per edge after the fill, and the last acknowledge trails by one edge
    task automatic wait_drained();
        @(posedge clk);
        while (!drained())
        begin
            @(posedge clk);
        end
        repeat (ROB_DEPTH + 2)
        begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic issue_mix(int n_rd, mem_shim_pkg::addr_t rd_base, int rd_span, int n_wr);
        int rd_left;
        int wr_left;
        rd_left = n_rd;
        wr_left = n_wr;
        while ((rd_left > 0) || (wr_left > 0))
        begin
            @(posedge clk);
            #1;
            rd_req_enable = 1'b0;
            wr_req_enable = 1'b0;
            if ((rd_left > 0) && rd_req_rdy && ($urandom % 4 != 0))
            begin
                rd_req_addr   = rd_base + mem_shim_pkg::addr_t'($urandom % rd_span);
                rd_req_enable = 1'b1;
                rd_left--;
            end
            if ((wr_left > 0) && wr_req_rdy && ($urandom % 4 != 0))
            begin
                wr_req_addr   = WRITE_BASE + mem_shim_pkg::addr_t'($urandom % WRITE_SPAN);
                wr_req_data   = {$urandom, $urandom};
                wr_req_enable = 1'b1;
                wr_left--;
            end
        end
        @(posedge clk);
        #1;
        rd_req_enable = 1'b0;
        wr_req_enable = 1'b0;
    endtask

    // Every write address is read once so each line shows its last write
    task automatic read_back_written();
        int i;
        i = 0;
        while (i < WRITE_SPAN)
        begin
            @(posedge clk);
            #1;
            rd_req_enable = 1'b0;
            if (rd_req_rdy)
            begin
                rd_req_addr   = WRITE_BASE + mem_shim_pkg::addr_t'(i);
                rd_req_enable = 1'b1;
                i++;
            end
        end
        @(posedge clk);
        #1;
        rd_req_enable = 1'b0;
    endtask

    // Banked credits run out, both stages fill and the platform side goes quiet
    task automatic hold_credits_phase();
        int quiet;
        int rd_snap;
        int wr_snap;
        credit_hold = 1'b1;
        quiet = 0;
        while (quiet < 16)
        begin
            @(posedge clk);
            #1;
            rd_req_enable = 1'b0;
            wr_req_enable = 1'b0;
            if (rd_req_rdy)
            begin
                rd_req_addr   = READ_BASE + mem_shim_pkg::addr_t'($urandom % READ_SPAN);
                rd_req_enable = 1'b1;
            end
            if (wr_req_rdy)
            begin
                wr_req_addr   = WRITE_BASE + mem_shim_pkg::addr_t'($urandom % WRITE_SPAN);
                wr_req_data   = {$urandom, $urandom};
                wr_req_enable = 1'b1;
            end
            quiet = (!rd_req_rdy && !wr_req_rdy) ? quiet + 1 : 0;
        end
        rd_snap = rd_spent;
        wr_snap = wr_spent;
        repeat (20)
        begin
            @(posedge clk);
        end
        #1;
        check_count("plat_rd_valid pulses while credits held", rd_spent - rd_snap, 0);
        check_count("plat_wr_valid pulses while credits held", wr_spent - wr_snap, 0);
        credit_hold = 1'b0;
    endtask

    // Reads pile up until every tag is outstanding and rd_req_rdy stays low
    task automatic fill_rob_phase();
        int low_cycles;
        rsp_hold = 1'b1;
        low_cycles = 0;
        while (low_cycles < 8)
        begin
            @(posedge clk);
            #1;
            rd_req_enable = 1'b0;
            if (rd_req_rdy)
            begin
                rd_req_addr   = READ_BASE + mem_shim_pkg::addr_t'($urandom % READ_SPAN);
                rd_req_enable = 1'b1;
                low_cycles    = 0;
            end
            else
            begin
                low_cycles++;
            end
        end
        check_count("reads outstanding with rd_req_rdy low", rd_accepted - rd_returned, ROB_DEPTH);
        rsp_hold = 1'b0;
        while (!rd_req_rdy)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    initial
    begin
        void'($urandom(SEED));
        reset_n           = 1'b0;
        rd_req_addr       = '0;
        rd_req_enable     = 1'b0;
        wr_req_addr       = '0;
        wr_req_data       = '0;
        wr_req_enable     = 1'b0;
        plat_rd_credit    = 1'b0;
        plat_wr_credit    = 1'b0;
        plat_rd_rsp_valid = 1'b0;
        plat_rd_rsp_tag   = '0;
        plat_rd_rsp_data  = '0;
        plat_wr_rsp_valid = 1'b0;
        repeat (5)
        begin
            @(posedge clk);
        end
        #1;
        reset_n = 1'b1;

        issue_mix(P1_READS, READ_BASE, READ_SPAN, P1_WRITES);
        wait_drained();
        read_back_written();
        wait_drained();
        hold_credits_phase();
        wait_drained();
        fill_rob_phase();
        wait_drained();

        // Nothing lost or duplicated over the whole run
        check_count("reads returned", rd_returned, rd_accepted);
        check_count("expected reads left", exp_rd_q.size(), 0);
        check_count("wr_ack total at end", ack_total, wr_accepted);
        $display("TB PASSED");
        $finish;
    end

endmodule
